/* Makefile */
VERILATOR ?= verilator
TOP       ?= slice_stage_controller_tb
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* source/decoder_pkg.sv */
package decoder_pkg;

    // decoder stages, follows the master's schedule
    typedef enum logic [2:0] {
        stage_idle                = 3'd0,
        stage_measurement_loading = 3'd1,
        stage_spread_cluster      = 3'd2,
        stage_sync_is_odd_cluster = 3'd3,
        stage_grow_boundary       = 3'd4,
        stage_result_calculating  = 3'd5
    } stage_e;

    // opcodes sent by the master
    typedef enum logic [2:0] {
        cmd_none    = 3'd0,
        cmd_advance = 3'd1,
        cmd_finish  = 3'd2,
        cmd_abort   = 3'd3
    } stage_cmd_e;

    typedef struct packed {
        stage_cmd_e opcode;
    } stage_cmd_t;

    // 12 bits covers 3 * clog2(16)
    localparam int ROOT_FIELD_WIDTH = 12;

    // one report word per PU, end word has last set
    typedef struct packed {
        logic                        last;
        logic                        touching_boundary;
        logic                        odd_cardinality;
        logic [ROOT_FIELD_WIDTH-1:0] root;
    } result_word_t;

endpackage

/* source/link_fifo.sv */
`timescale 1ns/1ps

module link_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 do_write;
    logic                 do_read;

    assign full     = count == (PTR_WIDTH + 1)'(DEPTH);
    assign empty    = count == '0;
    assign do_write = wr_en && !full; // overflow ignored
    assign do_read  = rd_en && !empty;
    assign dout     = mem[rd_ptr];    // head shows without a read

    always_ff @(posedge clk) begin
        if (do_write) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_read) rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_write && !do_read) count <= count + 1'b1;
            else if (do_read && !do_write) count <= count - 1'b1;
        end
    end

endmodule

/* source/result_streamer.sv */
`timescale 1ns/1ps

module result_streamer import decoder_pkg::*; #(
    parameter int CODE_DISTANCE_X = 3,
    parameter int CODE_DISTANCE_Z = 3,
    parameter int X_START = 0,
    parameter int X_END = 2,
    localparam int ROUNDS = (CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X
                                                                : CODE_DISTANCE_Z,
    localparam int ADDRESS_WIDTH = 3 * $clog2(ROUNDS),
    localparam int PU_COUNT = CODE_DISTANCE_X * CODE_DISTANCE_Z * ROUNDS
) (
    input  logic                              clk,
    input  logic                              reset,
    input  stage_e                            stage,
    input  logic [ADDRESS_WIDTH*PU_COUNT-1:0] roots,
    input  logic [PU_COUNT-1:0]               is_odd_cardinalities,
    input  logic [PU_COUNT-1:0]               is_touching_boundaries,
    input  logic                              fifo_full,
    output logic                              push,
    output result_word_t                      word,
    output logic                              report_done
);

    localparam int ROOTS_PER_ROUND = (X_END - X_START + 1) * CODE_DISTANCE_Z;
    localparam int ROOT_OFFSET     = X_START * CODE_DISTANCE_Z;
    localparam int PUS_PER_ROUND   = CODE_DISTANCE_X * CODE_DISTANCE_Z;
    localparam int LOCAL_WIDTH     = $clog2(ROOTS_PER_ROUND + 1);
    localparam int ROUND_WIDTH     = $clog2(ROUNDS + 1);
    localparam int PU_INDEX_WIDTH  = $clog2(PU_COUNT + 1);

    logic [LOCAL_WIDTH-1:0]    local_index;
    logic [ROUND_WIDTH-1:0]    round_index;
    logic [PU_INDEX_WIDTH-1:0] pu_index;
    logic                      active;
    logic                      in_rounds;

    assign active      = stage == stage_result_calculating;
    assign in_rounds   = round_index < ROUND_WIDTH'(ROUNDS);
    assign push        = active && !fifo_full;
    assign report_done = push && !in_rounds; // end word goes out

    // own columns only, rounds are PUS_PER_ROUND apart
    assign pu_index = in_rounds
        ? PU_INDEX_WIDTH'(ROOT_OFFSET + PUS_PER_ROUND * round_index + local_index)
        : '0;

    always_comb begin
        word = '0;
        if (in_rounds) begin
            word.touching_boundary = is_touching_boundaries[pu_index];
            word.odd_cardinality   = is_odd_cardinalities[pu_index];
            word.root = ROOT_FIELD_WIDTH'(roots[pu_index*ADDRESS_WIDTH +: ADDRESS_WIDTH]);
        end else begin
            word.last = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !active) begin
            local_index <= '0;
            round_index <= '0;
        end else if (push && in_rounds) begin
            if (local_index == LOCAL_WIDTH'(ROOTS_PER_ROUND - 1)) begin
                local_index <= '0;
                round_index <= round_index + 1'b1;
            end else begin
                local_index <= local_index + 1'b1;
            end
        end
    end

endmodule

/* source/slice_stage_controller.sv */
`timescale 1ns/1ps

module slice_stage_controller import decoder_pkg::*; #(
    parameter int CODE_DISTANCE_X = 3,
    parameter int CODE_DISTANCE_Z = 3,
    parameter int X_START = 0,
    parameter int X_END = 2,
    localparam int ROUNDS = (CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X
                                                                : CODE_DISTANCE_Z,
    localparam int ADDRESS_WIDTH = 3 * $clog2(ROUNDS),
    localparam int PU_COUNT = CODE_DISTANCE_X * CODE_DISTANCE_Z * ROUNDS,
    parameter int DEADLOCK_LIMIT = 10 * PU_COUNT
) (
    input  logic                              clk,
    input  logic                              reset,
    input  stage_cmd_t                        cmd_data,
    input  logic                              cmd_valid,
    output logic                              cmd_ready,
    input  logic [ADDRESS_WIDTH*PU_COUNT-1:0] roots,
    input  logic [PU_COUNT-1:0]               is_odd_cardinalities,
    input  logic [PU_COUNT-1:0]               is_touching_boundaries,
    output result_word_t                      report_data,
    output logic                              report_valid,
    input  logic                              report_ready,
    output stage_e                            stage,
    output logic                              result_valid,
    output logic [7:0]                        iteration_counter,
    output logic [31:0]                       cycle_counter,
    output logic                              deadlock
);

    stage_cmd_t   cmd_head;
    result_word_t word;
    logic         cmd_full;
    logic         cmd_empty;
    logic         cmd_pop;
    logic         report_full;
    logic         report_empty;
    logic         push;
    logic         report_done;

    assign cmd_ready    = !cmd_full;
    assign report_valid = !report_empty;

    link_fifo #(.WIDTH($bits(stage_cmd_t)), .DEPTH(16)) cmd_fifo (
        .clk(clk), .reset(reset),
        .wr_en(cmd_valid), .din(cmd_data), .full(cmd_full),
        .rd_en(cmd_pop), .dout(cmd_head), .empty(cmd_empty)
    );

    stage_sequencer #(
        .CODE_DISTANCE_X(CODE_DISTANCE_X), .CODE_DISTANCE_Z(CODE_DISTANCE_Z),
        .DEADLOCK_LIMIT(DEADLOCK_LIMIT)
    ) stage_sequencer_i (
        .clk(clk), .reset(reset),
        .cmd_head(cmd_head), .cmd_empty(cmd_empty), .cmd_pop(cmd_pop),
        .report_done(report_done), .stage(stage), .result_valid(result_valid),
        .iteration_counter(iteration_counter), .cycle_counter(cycle_counter),
        .deadlock(deadlock)
    );

    result_streamer #(
        .CODE_DISTANCE_X(CODE_DISTANCE_X), .CODE_DISTANCE_Z(CODE_DISTANCE_Z),
        .X_START(X_START), .X_END(X_END)
    ) result_streamer_i (
        .clk(clk), .reset(reset), .stage(stage),
        .roots(roots), .is_odd_cardinalities(is_odd_cardinalities),
        .is_touching_boundaries(is_touching_boundaries),
        .fifo_full(report_full), .push(push), .word(word), .report_done(report_done)
    );

    link_fifo #(.WIDTH($bits(result_word_t)), .DEPTH(16)) report_fifo (
        .clk(clk), .reset(reset),
        .wr_en(push), .din(word), .full(report_full),
        .rd_en(report_ready), .dout(report_data), .empty(report_empty)
    );

endmodule

/* source/stage_sequencer.sv */
`timescale 1ns/1ps

module stage_sequencer import decoder_pkg::*; #(
    parameter int CODE_DISTANCE_X = 3,
    parameter int CODE_DISTANCE_Z = 3,
    localparam int ROUNDS = (CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X
                                                                : CODE_DISTANCE_Z,
    localparam int PU_COUNT = CODE_DISTANCE_X * CODE_DISTANCE_Z * ROUNDS,
    parameter int DEADLOCK_LIMIT = 10 * PU_COUNT
) (
    input  logic        clk,
    input  logic        reset,
    input  stage_cmd_t  cmd_head,
    input  logic        cmd_empty,
    output logic        cmd_pop,
    input  logic        report_done,
    output stage_e      stage,
    output logic        result_valid,
    output logic [7:0]  iteration_counter,
    output logic [31:0] cycle_counter,
    output logic        deadlock
);

    stage_e      stage_next;
    stage_cmd_e  opcode;
    logic        has_cmd;
    logic [31:0] cycles_in_stage;

    assign has_cmd = !cmd_empty;
    assign opcode  = cmd_head.opcode;

    // result stage holds the queue until back in idle
    assign cmd_pop = has_cmd && (stage != stage_result_calculating);

    always_comb begin
        stage_next = stage;
        case (stage)
            stage_idle: begin
                if (has_cmd && opcode == cmd_advance) stage_next = stage_measurement_loading;
            end
            stage_measurement_loading: stage_next = stage_spread_cluster; // single cycle
            stage_spread_cluster: begin
                if (has_cmd && opcode == cmd_advance) stage_next = stage_sync_is_odd_cluster;
                else if (has_cmd && opcode == cmd_abort) stage_next = stage_idle;
            end
            stage_sync_is_odd_cluster: begin
                if (has_cmd) begin
                    case (opcode)
                        cmd_advance: stage_next = stage_grow_boundary;
                        cmd_finish:  stage_next = stage_result_calculating;
                        cmd_abort:   stage_next = stage_idle;
                        default:     stage_next = stage;
                    endcase
                end
            end
            stage_grow_boundary: begin
                if (has_cmd && opcode == cmd_advance) stage_next = stage_spread_cluster;
            end
            stage_result_calculating: begin
                if (report_done) stage_next = stage_idle;
            end
            default: stage_next = stage_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage        <= stage_idle;
            result_valid <= 1'b0;
        end else begin
            stage <= stage_next;
            if (stage_next == stage_measurement_loading) result_valid <= 1'b0;
            else if (report_done) result_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_counter <= '0;
            cycle_counter     <= '0;
        end else begin
            if (stage == stage_measurement_loading) iteration_counter <= '0;
            else if (stage == stage_sync_is_odd_cluster && stage_next == stage_grow_boundary)
                iteration_counter <= iteration_counter + 1'b1;

            if (stage == stage_measurement_loading) cycle_counter <= 32'd1;
            else if (!result_valid) cycle_counter <= cycle_counter + 1'b1;
        end
    end

    // deadlock watch, only spread and sync can hang
    always_ff @(posedge clk) begin
        if (reset) begin
            cycles_in_stage <= '0;
            deadlock        <= 1'b0;
        end else begin
            if (stage == stage_spread_cluster || stage == stage_sync_is_odd_cluster)
                cycles_in_stage <= cycles_in_stage + 1'b1;
            else
                cycles_in_stage <= '0;

            if (stage == stage_measurement_loading) deadlock <= 1'b0;
            else if (cycles_in_stage > 32'(DEADLOCK_LIMIT)) deadlock <= 1'b1;
        end
    end

endmodule

/* sources.f */
source/decoder_pkg.sv
source/link_fifo.sv
source/stage_sequencer.sv
source/result_streamer.sv
source/slice_stage_controller.sv
verification/stage_sequencer_chk.sv
verification/slice_stage_controller_tb.sv

/* verification/slice_stage_controller_tb.sv */
`timescale 1ns/1ps

module slice_stage_controller_tb import decoder_pkg::*; ();

    localparam int CODE_DISTANCE_X = 3;
    localparam int CODE_DISTANCE_Z = 3;
    localparam int X_START         = 1;
    localparam int X_END           = 2;
    localparam int ROUNDS          = (CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X
                                                                         : CODE_DISTANCE_Z;
    localparam int ADDRESS_WIDTH   = 3 * $clog2(ROUNDS);
    localparam int PU_COUNT        = CODE_DISTANCE_X * CODE_DISTANCE_Z * ROUNDS;
    localparam int MAX_CASES       = 64;
    localparam int STREAM_LIMIT    = 400;

    typedef logic [8*24-1:0] name_t;

    typedef struct packed {
        name_t      name;
        stage_cmd_e opcode;
        logic [7:0] hold;      // extra cycles before the checks
        stage_e     stage;
        logic [7:0] iteration;
        logic       deadlock;
        logic       report;    // drain the report stream after the checks
    } case_t;

    logic                              clk;
    logic                              reset;
    stage_cmd_t                        cmd_data;
    logic                              cmd_valid;
    logic                              cmd_ready;
    logic [ADDRESS_WIDTH*PU_COUNT-1:0] roots;
    logic [PU_COUNT-1:0]               is_odd_cardinalities;
    logic [PU_COUNT-1:0]               is_touching_boundaries;
    result_word_t                      report_data;
    logic                              report_valid;
    logic                              report_ready;
    stage_e                            stage;
    logic                              result_valid;
    logic [7:0]                        iteration_counter;
    logic [31:0]                       cycle_counter;
    logic                              deadlock;

    integer       seed;
    case_t        cases [MAX_CASES];
    int           case_count;
    int           hold_total;
    logic         cases_loaded;
    logic         failure_reported;
    logic         run_passed;
    logic         round_done;        // report finished since the last loading
    int           edge_count;        // rising edges so far
    int           load_edge;         // edge that starts the loading cycle of the round
    stage_e       last_stage;        // expected stage after the previous case
    result_word_t expected_words [$];

    slice_stage_controller #(
        .CODE_DISTANCE_X(CODE_DISTANCE_X), .CODE_DISTANCE_Z(CODE_DISTANCE_Z),
        .X_START(X_START), .X_END(X_END), .DEADLOCK_LIMIT(40)
    ) slice_stage_controller_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) edge_count <= edge_count + 1;

    task automatic stop_on_failure();
        failure_reported = 1'b1;
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input name_t test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %0s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    fields;
        string line;
        name_t name;
        int    op;
        int    hold;
        int    exp_stage;
        int    exp_iteration;
        int    exp_deadlock;
        int    report;
        fd = $fopen("verification/stage_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/stage_cases.txt");
            stop_on_failure();
        end
        case_count = 0;
        hold_total = 0;
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%s %d %d %d %d %d %d", name, op, hold, exp_stage,
                             exp_iteration, exp_deadlock, report);
            if (fields == 7 && case_count < MAX_CASES) begin // comment lines fall out here
                cases[case_count].name      = name;
                cases[case_count].opcode    = stage_cmd_e'(op[2:0]);
                cases[case_count].hold      = 8'(hold);
                cases[case_count].stage     = stage_e'(exp_stage[2:0]);
                cases[case_count].iteration = 8'(exp_iteration);
                cases[case_count].deadlock  = exp_deadlock[0];
                cases[case_count].report    = report[0];
                hold_total += hold;
                case_count++;
            end
        end
        $fclose(fd);
    endtask

    // own columns of every round, end word last
    task automatic build_expected_report();
        result_word_t w;
        int           pu;
        expected_words.delete();
        for (int r = 0; r < ROUNDS; r++) begin
            for (int x = X_START; x <= X_END; x++) begin
                for (int z = 0; z < CODE_DISTANCE_Z; z++) begin
                    pu = r * CODE_DISTANCE_X * CODE_DISTANCE_Z + x * CODE_DISTANCE_Z + z;
                    w = '0;
                    w.touching_boundary = is_touching_boundaries[pu];
                    w.odd_cardinality   = is_odd_cardinalities[pu];
                    w.root = ROOT_FIELD_WIDTH'(roots[pu*ADDRESS_WIDTH +: ADDRESS_WIDTH]);
                    expected_words.push_back(w);
                end
            end
        end
        w = '0;
        w.last = 1'b1;
        expected_words.push_back(w);
    endtask

    task automatic drain_report(input name_t test_name);
        result_word_t expected;
        int           cycles;
        int           rise_edge;
        build_expected_report();
        cycles = 0;
        rise_edge = -1;
        while (expected_words.size() > 0) begin
            if (result_valid && rise_edge < 0) rise_edge = edge_count;
            report_ready = 1'($random(seed)); // holds through the next rising edge
            if (report_valid && report_ready) begin
                expected = expected_words.pop_front();
                check_value(test_name, "report word", 32'(expected), 32'(report_data));
            end
            cycles++;
            if (cycles > STREAM_LIMIT) begin
                $display("report stream of %0s stalled before the end word", test_name);
                stop_on_failure();
            end
            @(negedge clk);
        end
        report_ready = 1'b0;
        cycles = 0;
        while (!result_valid) begin
            if (cycles > 20) begin
                $display("result_valid never rose after the report of %0s", test_name);
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
        if (rise_edge < 0) rise_edge = edge_count;
        check_value(test_name, "stage after report", 32'(stage_idle), 32'(stage));
        check_value(test_name, "cycle_counter", 32'(rise_edge - load_edge), cycle_counter);
        check_value(test_name, "report_valid after report", 32'd0, 32'(report_valid));
        round_done = 1'b1;
    endtask

    task automatic run_case(input case_t c);
        assert (cmd_ready) else begin
            $display("command FIFO refused the command of %0s", c.name);
            stop_on_failure();
        end
        if (last_stage == stage_idle && c.opcode == cmd_advance)
            load_edge = edge_count + 2; // written next edge, loading one edge later
        cmd_data.opcode = c.opcode;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        repeat (2 + c.hold) @(negedge clk);
        if (c.stage != stage_idle) round_done = 1'b0;
        check_value(c.name, "stage", 32'(c.stage), 32'(stage));
        check_value(c.name, "iteration_counter", 32'(c.iteration), 32'(iteration_counter));
        check_value(c.name, "deadlock", 32'(c.deadlock), 32'(deadlock));
        check_value(c.name, "result_valid", 32'(round_done), 32'(result_valid));
        if (c.stage != stage_result_calculating)
            check_value(c.name, "report_valid", 32'd0, 32'(report_valid));
        if (c.report) drain_report(c.name);
        last_stage = c.report ? stage_idle : c.stage;
    endtask

    initial begin
        seed             = 32'h53507c53;
        reset            = 1'b1;
        cmd_valid        = 1'b0;
        cmd_data         = '0;
        report_ready     = 1'b0;
        cases_loaded     = 1'b0;
        failure_reported = 1'b0;
        run_passed       = 1'b0;
        round_done       = 1'b0;
        edge_count       = 0;
        load_edge        = 0;
        last_stage       = stage_idle;
        for (int i = 0; i < ADDRESS_WIDTH * PU_COUNT; i++) roots[i] = 1'($random(seed));
        for (int i = 0; i < PU_COUNT; i++) begin
            is_odd_cardinalities[i]   = 1'($random(seed));
            is_touching_boundaries[i] = 1'($random(seed));
        end
        load_cases();
        cases_loaded = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("after_reset", "stage", 32'(stage_idle), 32'(stage));
        check_value("after_reset", "cycle_counter", 32'd0, cycle_counter);
        check_value("after_reset", "result_valid", 32'd0, 32'(result_valid));
        for (int i = 0; i < case_count; i++) run_case(cases[i]);
        run_passed = 1'b1;
        $display("TEST PASSED");
        $finish;
    end

    // watchdog
    initial begin
        wait (cases_loaded);
        repeat (case_count * 10 + hold_total + 400) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles",
                 case_count * 10 + hold_total + 400);
        stop_on_failure();
    end

    // run ended by a bound assertion
    final begin
        if (!run_passed && !failure_reported) $display("TEST FAILED");
    end

endmodule

/* verification/stage_cases.txt */
# name opcode(0 none 1 advance 2 finish 3 abort) hold stage iteration deadlock report
# stage 0 idle 1 loading 2 spread 3 sync 4 grow 5 result, report 1 drains the stream
idle_finish        2  0 0 0 0 0
idle_abort         3  0 0 0 0 0
start_round        1  0 2 0 0 0
spread_finish      2  0 2 0 0 0
spread_advance     1  0 3 0 0 0
sync_advance       1  0 4 1 0 0
grow_finish        2  0 4 1 0 0
grow_abort         3  0 4 1 0 0
grow_advance       1  0 2 1 0 0
spread_advance_2   1  0 3 1 0 0
sync_advance_2     1  0 4 2 0 0
grow_advance_2     1  0 2 2 0 0
spread_advance_3   1  0 3 2 0 0
sync_finish        2  0 5 2 0 0
result_finish_held 2  0 5 2 0 1
new_round          1  0 2 0 0 0
spread_stall       0 45 2 0 1 0
stalled_abort      3  0 0 0 1 0
deadlock_clear     1  0 2 0 0 0
spread_advance_4   1  0 3 0 0 0
sync_abort         3  0 0 0 0 0
last_round         1  0 2 0 0 0
last_advance       1  0 3 0 0 0
last_finish        2  0 5 0 0 1

/* verification/stage_sequencer_chk.sv */
`timescale 1ns/1ps

module stage_sequencer_chk import decoder_pkg::*; (
    input logic   clk,
    input logic   reset,
    input stage_e stage,
    input logic   cmd_pop,
    input logic   cmd_empty
);

    loading_one_cycle: assert property (
        @(posedge clk) disable iff (reset)
        stage == stage_measurement_loading |=> stage == stage_spread_cluster
    ) else $error("measurement loading did not last exactly one cycle");

    // result stage waits for the report, then idle only
    result_exit_to_idle: assert property (
        @(posedge clk) disable iff (reset)
        stage == stage_result_calculating |=>
            (stage == stage_result_calculating || stage == stage_idle)
    ) else $error("result calculating left to a stage other than idle");

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) !(cmd_pop && cmd_empty)
    ) else $error("command pop while the command FIFO is empty");

endmodule

bind stage_sequencer stage_sequencer_chk stage_sequencer_chk_i (
    .clk(clk), .reset(reset), .stage(stage), .cmd_pop(cmd_pop), .cmd_empty(cmd_empty)
);
